/* hdl/bridge_ram_pkg.sv */
// Shared types and constants for the 32-bit host to 16-bit word memory bridge
`default_nettype none

package bridge_ram_pkg;

	// Host request as seen on the host bus, held as a level until done
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] addr;
		logic [31:0] wr_data;
	} bridge_req_t;

	// One 16-bit word access towards the memory
	// rd and wr are single-cycle strobes
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [25:0] addr;
		logic [15:0] data;
	} ram_cmd_t;

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_wait_hi,
		st_wait_lo,
		st_wait_write_lo
	} seq_state_e;

	typedef enum logic {
		op_read,
		op_write
	} bridge_op_e;

	// Top address byte of the host's own register space
	localparam logic [7:0] IGNORED_REGION = 8'hf8;

endpackage

`default_nettype wire

/* hdl/bridge_ram_top.sv */
// Top level of the host to 16-bit word memory bridge
`timescale 1ns/1ps
`default_nettype none

module bridge_ram_top #(
	parameter int RAM_ADDR_WIDTH = 10,
	parameter int BUSY_CYCLES    = 3
) (
	input  wire                           clk_sys,
	input  wire                           reset_l,
	input  wire                           big_endian,
	input  wire bridge_ram_pkg::bridge_req_t bridge_req,
	output logic [31:0]                   bridge_rd_data,
	output logic                          bridge_processing,
	output logic                          bridge_done
);

	import bridge_ram_pkg::*;

	localparam int AD_W = $bits(bridge_req.addr) + $bits(bridge_req.wr_data);

	logic            rd_sync;
	logic            rd_rise;
	logic            wr_sync;
	logic            wr_rise;
	logic [AD_W-1:0] ad_sync;
	bridge_req_t     req_sync;
	ram_cmd_t        ram_cmd;
	logic [15:0]     word_q;
	logic            word_busy;

	bridge_synchronizer #(.WIDTH(1)) sync_rd (
		.clk_sys(clk_sys), .reset_l(reset_l), .async_in(bridge_req.rd),
		.sync_out(rd_sync), .rise(rd_rise), .fall());

	bridge_synchronizer #(.WIDTH(1)) sync_wr (
		.clk_sys(clk_sys), .reset_l(reset_l), .async_in(bridge_req.wr),
		.sync_out(wr_sync), .rise(wr_rise), .fall());

	// Address and write data only need the level
	bridge_synchronizer #(.WIDTH(AD_W)) sync_ad (
		.clk_sys(clk_sys), .reset_l(reset_l),
		.async_in({bridge_req.addr, bridge_req.wr_data}),
		.sync_out(ad_sync), .rise(), .fall());

	assign req_sync = {rd_sync, wr_sync, ad_sync};

	bridge_word_sequencer seq0 (
		.clk_sys(clk_sys), .reset_l(reset_l), .big_endian(big_endian),
		.req(req_sync), .rd_rise(rd_rise), .wr_rise(wr_rise),
		.ram_cmd(ram_cmd), .word_q(word_q), .word_busy(word_busy),
		.bridge_rd_data(bridge_rd_data), .bridge_processing(bridge_processing),
		.bridge_done(bridge_done));

	word_sram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH), .BUSY_CYCLES(BUSY_CYCLES)) sram0 (
		.clk_sys(clk_sys), .reset_l(reset_l), .ram_cmd(ram_cmd),
		.word_q(word_q), .word_busy(word_busy));

endmodule

`default_nettype wire

/* hdl/bridge_synchronizer.sv */
// Three-flop clock domain synchronizer with edge strobes taken from bit 0
`timescale 1ns/1ps
`default_nettype none

module bridge_synchronizer #(
	parameter int WIDTH = 1
) (
	input  wire              clk_sys,
	input  wire              reset_l,
	input  wire [WIDTH-1:0]  async_in,
	output logic [WIDTH-1:0] sync_out,
	output logic             rise,
	output logic             fall
);

	logic [WIDTH-1:0] stage1;
	logic [WIDTH-1:0] stage2;
	logic [WIDTH-1:0] stage3;

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			stage1 <= '0;
			stage2 <= '0;
			stage3 <= '0;
			rise   <= 1'b0;
			fall   <= 1'b0;
		end else begin
			// First stage may go metastable, the next two let it settle
			stage1 <= async_in;
			stage2 <= stage1;
			stage3 <= stage2;
			// Edge strobes line up with the cycle stage3 takes the new level
			rise   <= stage2[0] & ~stage3[0];
			fall   <= ~stage2[0] & stage3[0];
		end
	end

	assign sync_out = stage3;

endmodule

`default_nettype wire

/* hdl/bridge_word_sequencer.sv */
// Sequencer that splits a 32-bit host transfer into two 16-bit word memory accesses
`timescale 1ns/1ps
`default_nettype none

module bridge_word_sequencer (
	input  wire                          clk_sys,
	input  wire                          reset_l,
	input  wire                          big_endian,
	input  wire bridge_ram_pkg::bridge_req_t req,
	input  wire                          rd_rise,
	input  wire                          wr_rise,
	output bridge_ram_pkg::ram_cmd_t     ram_cmd,
	input  wire [15:0]                   word_q,
	input  wire                          word_busy,
	output logic [31:0]                  bridge_rd_data,
	output logic                         bridge_processing,
	output logic                         bridge_done
);

	import bridge_ram_pkg::*;

	seq_state_e  state;
	bridge_op_e  op;
	logic        be_q;
	logic        settle;
	logic [31:0] wdata_q;
	logic [15:0] rd_hi_q;
	logic        accept;

	// Little-endian swaps the bytes of a half, the halves keep their order
	function automatic logic [15:0] order_word(input logic [15:0] w, input logic be);
		return be ? w : {w[7:0], w[15:8]};
	endfunction

	// Register region of the host is never served
	assign accept = (rd_rise || wr_rise) && (req.addr[31:24] != IGNORED_REGION);

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			state             <= st_idle;
			op                <= op_read;
			be_q              <= 1'b1;
			settle            <= 1'b0;
			wdata_q           <= '0;
			rd_hi_q           <= '0;
			ram_cmd           <= '0;
			bridge_rd_data    <= '0;
			bridge_processing <= 1'b0;
			bridge_done       <= 1'b0;
		end else begin
			// Strobes default low
			ram_cmd.rd  <= 1'b0;
			ram_cmd.wr  <= 1'b0;
			bridge_done <= 1'b0;

			case (state)
				st_idle: begin
					if (accept) begin
						state             <= st_request;
						op                <= wr_rise ? op_write : op_read;
						be_q              <= big_endian;
						wdata_q           <= {order_word(req.wr_data[31:16], big_endian),
							order_word(req.wr_data[15:0], big_endian)};
						ram_cmd.addr      <= req.addr[25:0];
						bridge_processing <= 1'b1;
					end
				end

				// Upper half goes out first, at the host address
				st_request: begin
					if (!word_busy) begin
						settle <= 1'b1;
						if (op == op_read) begin
							ram_cmd.rd <= 1'b1;
							state      <= st_wait_hi;
						end else begin
							ram_cmd.wr   <= 1'b1;
							ram_cmd.data <= wdata_q[31:16];
							state        <= st_wait_write_lo;
						end
					end
				end

				st_wait_hi: begin
					// Busy only shows one cycle after the strobe
					if (settle) begin
						settle <= 1'b0;
					end else if (!word_busy) begin
						// Upper half is parked so read data only moves on done
						rd_hi_q      <= order_word(word_q, be_q);
						ram_cmd.rd   <= 1'b1;
						ram_cmd.addr <= ram_cmd.addr + 26'd2;
						settle       <= 1'b1;
						state        <= st_wait_lo;
					end
				end

				st_wait_lo: begin
					if (settle) begin
						settle <= 1'b0;
					end else if (!word_busy) begin
						bridge_rd_data    <= {rd_hi_q, order_word(word_q, be_q)};
						bridge_done       <= 1'b1;
						bridge_processing <= 1'b0;
						state             <= st_idle;
					end
				end

				// Lower half write, done goes out with the strobe
				st_wait_write_lo: begin
					if (settle) begin
						settle <= 1'b0;
					end else if (!word_busy) begin
						ram_cmd.wr        <= 1'b1;
						ram_cmd.data      <= wdata_q[15:0];
						ram_cmd.addr      <= ram_cmd.addr + 26'd2;
						bridge_done       <= 1'b1;
						bridge_processing <= 1'b0;
						state             <= st_idle;
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	a_strobe_exclusive: assert property (@(posedge clk_sys) disable iff (!reset_l)
		!(ram_cmd.rd && ram_cmd.wr))
		else $error("word read and write strobes overlap");

	// A completion always closes a transfer that was in progress
	a_done_after_processing: assert property (@(posedge clk_sys) disable iff (!reset_l)
		bridge_done |-> $past(bridge_processing))
		else $error("done without a transfer in progress");

	a_state_legal: assert property (@(posedge clk_sys) disable iff (!reset_l)
		state inside {st_idle, st_request, st_wait_hi, st_wait_lo, st_wait_write_lo})
		else $error("sequencer state out of range");

	// Host never raises read and write together
	a_host_one_request: assert property (@(posedge clk_sys) disable iff (!reset_l)
		!(req.rd && req.wr))
		else $error("host read and write requests both high");

endmodule

`default_nettype wire

/* hdl/word_sram.sv */
// Behavioral single-port 16-bit word memory with a fixed busy window per access
`timescale 1ns/1ps
`default_nettype none

module word_sram #(
	parameter int RAM_ADDR_WIDTH = 10,
	parameter int BUSY_CYCLES    = 3
) (
	input  wire                          clk_sys,
	input  wire                          reset_l,
	input  wire bridge_ram_pkg::ram_cmd_t ram_cmd,
	output logic [15:0]                  word_q,
	output logic                         word_busy
);

	localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

	logic [15:0]               mem [0:(2**RAM_ADDR_WIDTH)-1];
	logic [RAM_ADDR_WIDTH-1:0] word_idx;
	logic [CNT_W-1:0]          busy_cnt;
	logic                      strobe;

	// Byte address to word index, anything above the array wraps
	assign word_idx = ram_cmd.addr[RAM_ADDR_WIDTH:1];
	assign strobe   = ram_cmd.rd | ram_cmd.wr;

	always_ff @(posedge clk_sys) begin
		if (ram_cmd.wr) begin
			mem[word_idx] <= ram_cmd.data;
		end
		// Read word stays put until the next read strobe
		if (ram_cmd.rd) begin
			word_q <= mem[word_idx];
		end
	end

	// Counter loads on a strobe and runs down to zero
	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			busy_cnt <= '0;
		end else if (strobe) begin
			busy_cnt <= CNT_W'(BUSY_CYCLES);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign word_busy = (busy_cnt != '0);

	a_no_strobe_when_busy: assert property (@(posedge clk_sys) disable iff (!reset_l)
		strobe |-> !word_busy)
		else $error("memory access strobed while busy");

	a_busy_cycles_min: assert property (@(posedge clk_sys) BUSY_CYCLES >= 1)
		else $error("BUSY_CYCLES must be at least 1");

endmodule

`default_nettype wire

/* project.f */
hdl/bridge_ram_pkg.sv
hdl/bridge_synchronizer.sv
hdl/bridge_word_sequencer.sv
hdl/word_sram.sv
hdl/bridge_ram_top.sv
verif/bridge_ram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=bridge_ram_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module bridge_ram_tb -f project.f \
	-Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./"$OBJ_DIR"/"$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation passed"
exit 0

/* verif/bridge_ram_tb.sv */
// Testbench for the host to 16-bit word memory bridge with a reference memory model
`timescale 1ns/1ps
`default_nettype none

module bridge_ram_tb;

	import bridge_ram_pkg::*;

	localparam int DONE_TIMEOUT  = 60;
	localparam int IGNORE_WINDOW = 40;
	localparam int N_WORDS       = 32;

	logic        clk_sys;
	logic        reset_l;
	logic        big_endian;
	bridge_req_t bridge_req;
	logic [31:0] bridge_rd_data;
	logic        bridge_processing;
	logic        bridge_done;

	logic [31:0] lfsr;
	logic [15:0] ref_mem [int];
	logic [31:0] addr_list [N_WORDS];
	string       cur_test;
	logic        cur_is_read;
	logic [31:0] exp_data;
	logic [31:0] rd_hold;
	int          checks_run;
	int          value_errors;
	int          other_errors;
	int          reads_expected;
	int          reads_checked;

	bridge_ram_top dut0 (
		.clk_sys(clk_sys), .reset_l(reset_l), .big_endian(big_endian),
		.bridge_req(bridge_req), .bridge_rd_data(bridge_rd_data),
		.bridge_processing(bridge_processing), .bridge_done(bridge_done));

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] swap_bytes_in_halves(input logic [31:0] v);
		return {v[23:16], v[31:24], v[7:0], v[15:8]};
	endfunction

	// Memory word index from a byte address, upper bits wrap
	function automatic int word_index(input logic [31:0] addr);
		return int'(addr[10:1]);
	endfunction

	// Upper half goes to addr, lower half to addr + 2
	function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
		input logic be);
		logic [31:0] v;
		v = be ? data : swap_bytes_in_halves(data);
		ref_mem[word_index(addr)]     = v[31:16];
		ref_mem[word_index(addr + 2)] = v[15:0];
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic be);
		logic [31:0] v;
		v = {ref_mem[word_index(addr)], ref_mem[word_index(addr + 2)]};
		return be ? v : swap_bytes_in_halves(v);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// 4-byte aligned, 512 locations in a 1024-word memory
	task automatic random_addr(output logic [31:0] addr);
		logic [31:0] v;
		draw_bits(9, v);
		addr = {21'd0, v[8:0], 2'b00};
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks_run++;
		assert (act === exp) else begin
			value_errors++;
			$display("ERROR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic set_order(input logic be);
		@(negedge clk_sys);
		big_endian = be;
	endtask

	task automatic wait_done(input string name, output logic seen);
		int cyc;
		cyc  = 0;
		seen = 1'b0;
		while (!seen && cyc < DONE_TIMEOUT) begin
			@(negedge clk_sys);
			seen = bridge_done;
			cyc++;
		end
		assert (seen) else begin
			other_errors++;
			$display("Timeout: no done within %0d cycles in %s", DONE_TIMEOUT, name);
		end
	endtask

	// Address and data settle two cycles before the request level rises
	task automatic host_access(input string name, input logic is_write,
		input logic [31:0] addr, input logic [31:0] data);
		logic seen;
		@(negedge clk_sys);
		bridge_req.addr    = addr;
		bridge_req.wr_data = data;
		cur_test           = name;
		cur_is_read        = !is_write;
		if (is_write) begin
			ref_write(addr, data, big_endian);
		end else begin
			exp_data = ref_read(addr, big_endian);
			reads_expected++;
		end
		repeat (2) @(negedge clk_sys);
		bridge_req.rd = !is_write;
		bridge_req.wr = is_write;
		wait_done(name, seen);
		bridge_req.rd = 1'b0;
		bridge_req.wr = 1'b0;
		repeat (5) @(negedge clk_sys);
	endtask

	task automatic ignored_access(input string name, input logic is_write,
		input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk_sys);
		bridge_req.addr    = addr;
		bridge_req.wr_data = data;
		cur_test           = name;
		cur_is_read        = 1'b0;
		repeat (2) @(negedge clk_sys);
		bridge_req.rd = !is_write;
		bridge_req.wr = is_write;
		for (int cyc = 0; cyc < IGNORE_WINDOW; cyc++) begin
			@(negedge clk_sys);
			assert (!bridge_done) else begin
				other_errors++;
				$display("Done strobe seen for ignored-region request in %s", name);
			end
			assert (!bridge_processing) else begin
				other_errors++;
				$display("Processing went high for ignored-region request in %s", name);
			end
		end
		bridge_req.rd = 1'b0;
		bridge_req.wr = 1'b0;
		repeat (5) @(negedge clk_sys);
	endtask

	task automatic round_trip(input string name, input logic be);
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] r;
		logic [31:0] tmp;
		int          j;
		set_order(be);
		for (int i = 0; i < N_WORDS; i++) begin
			random_addr(a);
			draw_bits(32, d);
			addr_list[i] = a;
			host_access({name, "_write"}, 1'b1, a, d);
		end
		// Fisher-Yates shuffle of the read order
		for (int i = N_WORDS - 1; i > 0; i--) begin
			draw_bits(8, r);
			j            = int'(r % (i + 1));
			tmp          = addr_list[i];
			addr_list[i] = addr_list[j];
			addr_list[j] = tmp;
		end
		for (int i = 0; i < N_WORDS; i++) begin
			host_access({name, "_read"}, 1'b0, addr_list[i], 32'h0);
		end
	endtask

	// Compares every read completion against the reference
	// Between completions the read data must hold its last value
	always @(negedge clk_sys) begin
		if (reset_l && bridge_done && cur_is_read) begin
			reads_checked++;
			check_value(cur_test, exp_data, bridge_rd_data);
			rd_hold = exp_data;
		end else if (reset_l) begin
			check_value({cur_test, "_hold"}, rd_hold, bridge_rd_data);
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] v;
		reset_l        = 1'b0;
		big_endian     = 1'b1;
		bridge_req     = '0;
		lfsr           = 32'd65701;
		cur_test       = "reset";
		cur_is_read    = 1'b0;
		exp_data       = '0;
		rd_hold        = '0;
		checks_run     = 0;
		value_errors   = 0;
		other_errors   = 0;
		reads_expected = 0;
		reads_checked  = 0;
		repeat (8) @(negedge clk_sys);
		reset_l = 1'b1;
		@(negedge clk_sys);
		check_value("reset_rd_data", 32'h0, bridge_rd_data);
		check_value("reset_done", 32'h0, {31'd0, bridge_done});
		check_value("reset_processing", 32'h0, {31'd0, bridge_processing});

		round_trip("be_round_trip", 1'b1);
		round_trip("le_round_trip", 1'b0);

		// Written big-endian, read back little-endian
		set_order(1'b1);
		for (int i = 0; i < 8; i++) begin
			random_addr(addr_list[i]);
			draw_bits(32, d);
			host_access("cross_write", 1'b1, addr_list[i], d);
		end
		set_order(1'b0);
		for (int i = 0; i < 8; i++) begin
			host_access("cross_read", 1'b0, addr_list[i], 32'h0);
		end

		// Neighbors of an overwritten location keep their data
		set_order(1'b1);
		draw_bits(9, v);
		if (v[8:0] == 9'd0) v[8:0] = 9'd1;
		if (v[8:0] == 9'd511) v[8:0] = 9'd510;
		a = {21'd0, v[8:0], 2'b00};
		for (int k = -1; k <= 1; k++) begin
			draw_bits(32, d);
			host_access("neighbor_fill", 1'b1, a + 32'(4 * k), d);
		end
		draw_bits(32, d);
		host_access("overwrite", 1'b1, a, d);
		for (int k = -1; k <= 1; k++) begin
			host_access("neighbor_read", 1'b0, a + 32'(4 * k), 32'h0);
		end

		random_addr(a);
		draw_bits(32, d);
		host_access("alias_fill", 1'b1, a, d);
		ignored_access("ignored_write", 1'b1, {IGNORED_REGION, a[23:0]}, ~d);
		ignored_access("ignored_read", 1'b0, {IGNORED_REGION, a[23:0]}, 32'h0);
		host_access("alias_read", 1'b0, a, 32'h0);

		assert (reads_checked == reads_expected) else begin
			other_errors++;
			$display("Only %0d of %0d read completions were checked", reads_checked,
				reads_expected);
		end
		$display("Checks: %0d, value errors: %0d, other errors: %0d", checks_run,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
